/* logic/exec_pkg.sv */
// ======================================================================
// Shared widths, micro-instruction field positions, register and flag
// indices and ALU group and function codes of the execution stage
// ======================================================================
`default_nettype none

package exec_pkg;

  // Data widths
  typedef logic [15:0] word_t;     // Register or data word
  typedef logic [19:0] addr20_t;   // Physical memory address
  typedef logic [3:0]  reg_idx_t;  // Register number
  typedef logic [8:0]  flags_t;    // of df if tf sf zf af pf cf
  typedef logic [35:0] micro_t;    // Micro-instruction word
  typedef logic [2:0]  alu_grp_t;
  typedef logic [2:0]  alu_fn_t;

  // Micro-instruction fields, LSB positions and single bits
  localparam int S_LSB      = 0;   // Segment select, 2 bits
  localparam int A_LSB      = 2;
  localparam int B_LSB      = 6;   // Also the condition code
  localparam int C_LSB      = 10;  // Bit 0 also selects CX mode
  localparam int D_LSB      = 14;  // Destination
  localparam int WRFL_BIT   = 18;
  localparam int WE_BIT     = 19;
  localparam int WR_BIT     = 20;
  localparam int WRCND_BIT  = 21;
  localparam int GRP_LSB    = 23;
  localparam int FN_LSB     = 26;
  localparam int BYTE_BIT   = 29;
  localparam int MEMALU_BIT = 30;  // 1 writes the ALU result, 0 writes memout
  localparam int MIO_BIT    = 32;
  localparam int BIMM_BIT   = 33;
  localparam int RBYTE_BIT  = 34;  // Byte view on read ports A and B
  localparam int CBYTE_BIT  = 35;  // Byte view on read port C

  // Register file layout
  localparam int       NUM_REGS = 16;
  localparam reg_idx_t REG_CX   = 4'd1;
  localparam reg_idx_t REG_SEG0 = 4'd8;   // es, cs, ss, ds from here up
  localparam reg_idx_t REG_CS   = 4'd9;
  localparam reg_idx_t REG_IP   = 4'd15;
  localparam word_t    CS_RESET = 16'hf000;
  localparam word_t    IP_RESET = 16'hfff0;

  // Flag bit positions within flags_t
  localparam int FL_OF = 8;
  localparam int FL_SF = 4;
  localparam int FL_ZF = 3;
  localparam int FL_PF = 1;
  localparam int FL_CF = 0;

  // ALU groups
  localparam alu_grp_t ALU_ARITH = 3'd0;
  localparam alu_grp_t ALU_LOGIC = 3'd1;
  localparam alu_grp_t ALU_SHIFT = 3'd2;
  localparam alu_grp_t ALU_ADDR  = 3'd3;

  // Functions, arithmetic group
  localparam alu_fn_t FN_ADD = 3'd0;
  localparam alu_fn_t FN_ADC = 3'd1;
  localparam alu_fn_t FN_SUB = 3'd2;
  localparam alu_fn_t FN_SBB = 3'd3;
  localparam alu_fn_t FN_INC = 3'd4;
  localparam alu_fn_t FN_DEC = 3'd5;
  // Functions, logic group
  localparam alu_fn_t FN_AND  = 3'd0;
  localparam alu_fn_t FN_OR   = 3'd1;
  localparam alu_fn_t FN_XOR  = 3'd2;
  localparam alu_fn_t FN_NOT  = 3'd3;
  localparam alu_fn_t FN_PASS = 3'd4;  // Passes operand B
  // Functions, shift group, all by one
  localparam alu_fn_t FN_SHL = 3'd0;
  localparam alu_fn_t FN_SHR = 3'd1;
  localparam alu_fn_t FN_SAR = 3'd2;
  localparam alu_fn_t FN_ROL = 3'd3;
  localparam alu_fn_t FN_ROR = 3'd4;

endpackage

`default_nettype wire

/* logic/exec_reg_port_if.sv */
// ======================================================================
// Register port between the stage controller and the register file
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

interface exec_reg_port_if;
  exec_pkg::reg_idx_t addr_a, addr_b, addr_c;  // Read ports
  exec_pkg::reg_idx_t addr_d;                  // Write port
  logic [1:0]         addr_s;                  // Segment 8 + addr_s
  logic               a_byte, b_byte, c_byte;  // Byte views per read port
  logic               wr_en;
  logic               wr_byte;                 // Replace one byte only
  exec_pkg::word_t    wr_data;
  exec_pkg::word_t    a, b, c, s;              // Read data
  logic               cx_zero;

  modport ctrl (
    output addr_a, addr_b, addr_c, addr_d, addr_s,
    output a_byte, b_byte, c_byte,
    output wr_en, wr_byte, wr_data,
    input  a, b, c, s, cx_zero
  );

  modport regs (
    input  addr_a, addr_b, addr_c, addr_d, addr_s,
    input  a_byte, b_byte, c_byte,
    input  wr_en, wr_byte, wr_data,
    output a, b, c, s, cx_zero
  );
endinterface

`default_nettype wire

/* logic/exec_regfile.sv */
// ======================================================================
// Sixteen word registers with 8086 byte views, one write port and the
// 9-bit flag register
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module exec_regfile (
  input  logic                  clk,
  input  logic                  reset,
  exec_reg_port_if.regs         port,
  input  exec_pkg::flags_t      flags_in,
  input  logic                  flags_we,
  output exec_pkg::flags_t      flags,
  output exec_pkg::word_t       cs,
  output exec_pkg::word_t       ip
);

  exec_pkg::word_t  regs [exec_pkg::NUM_REGS];
  exec_pkg::reg_idx_t d_lo;  // Register holding the addressed byte

  // Word read or byte 0..3 low and 4..7 high of registers 0..3
  function automatic exec_pkg::word_t byte_view(input exec_pkg::word_t w_word,
                                                input exec_pkg::word_t w_lo,
                                                input logic hi,
                                                input logic byte_v);
    if (!byte_v)
      return w_word;
    return hi ? {8'h00, w_lo[15:8]} : {8'h00, w_lo[7:0]};  // Zero-extended
  endfunction

  assign port.a = byte_view(regs[port.addr_a], regs[{2'b00, port.addr_a[1:0]}],
                            port.addr_a[2], port.a_byte);
  assign port.b = byte_view(regs[port.addr_b], regs[{2'b00, port.addr_b[1:0]}],
                            port.addr_b[2], port.b_byte);
  assign port.c = byte_view(regs[port.addr_c], regs[{2'b00, port.addr_c[1:0]}],
                            port.addr_c[2], port.c_byte);
  assign port.s = regs[exec_pkg::REG_SEG0 + exec_pkg::reg_idx_t'(port.addr_s)];

  assign port.cx_zero = regs[exec_pkg::REG_CX] == '0;  // For loop-style conditions
  assign cs = regs[exec_pkg::REG_CS];
  assign ip = regs[exec_pkg::REG_IP];

  assign d_lo = {2'b00, port.addr_d[1:0]};

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < exec_pkg::NUM_REGS; i++)
        regs[i] <= '0;
      regs[exec_pkg::REG_CS] <= exec_pkg::CS_RESET;  // Boot vector f000:fff0
      regs[exec_pkg::REG_IP] <= exec_pkg::IP_RESET;
      flags <= '0;
    end else begin
      if (port.wr_en) begin
        if (!port.wr_byte)
          regs[port.addr_d] <= port.wr_data;
        else if (port.addr_d[2])
          regs[d_lo][15:8] <= port.wr_data[7:0];  // ah, ch, dh, bh
        else
          regs[d_lo][7:0] <= port.wr_data[7:0];   // al, cl, dl, bl
      end
      if (flags_we)
        flags <= flags_in;
    end
  end

  // Reset lands on the boot segment
  a_cs_reset : assert property (@(posedge clk) reset |=> cs == exec_pkg::CS_RESET)
    else $error("exec_regfile: cs not at reset value after reset");

endmodule

`default_nettype wire

/* logic/exec_alu.sv */
// ======================================================================
// Combinational ALU: add/sub, logic, shift by one, segment address,
// with of, sf, zf, pf and cf at byte or word width
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
  input  exec_pkg::alu_grp_t grp,
  input  exec_pkg::alu_fn_t  fn,
  input  exec_pkg::word_t    x,
  input  exec_pkg::word_t    y,
  input  exec_pkg::word_t    seg,
  input  exec_pkg::word_t    off,
  input  logic               word_op,
  input  exec_pkg::flags_t   flags_in,
  output exec_pkg::word_t    result,
  output exec_pkg::addr20_t  ea,
  output exec_pkg::flags_t   flags_out
);

  exec_pkg::word_t top;     // Sign bit of the operating width
  exec_pkg::word_t mask;    // Width mask
  exec_pkg::word_t y_op;    // Adder B input
  exec_pkg::word_t ar;      // Adder result
  exec_pkg::word_t lg;
  exec_pkg::word_t sh;
  logic [16:0]     sum_w;
  logic [8:0]      sum_b;
  logic            sub_op, c_in, step, msb_x;
  logic            ar_cf, ar_of, sh_cf, sh_of;

  assign top   = word_op ? 16'h8000 : 16'h0080;
  assign mask  = word_op ? 16'hffff : 16'h00ff;
  assign msb_x = |(x & top);

  // Subtraction as x + ~y + ~borrow
  assign step   = fn == exec_pkg::FN_INC || fn == exec_pkg::FN_DEC;
  assign sub_op = fn == exec_pkg::FN_SUB || fn == exec_pkg::FN_SBB || fn == exec_pkg::FN_DEC;
  assign c_in   = (fn == exec_pkg::FN_ADC || fn == exec_pkg::FN_SBB) & flags_in[exec_pkg::FL_CF];
  assign y_op   = (step ? 16'h0001 : y) ^ {16{sub_op}};

  assign sum_w = {1'b0, x} + {1'b0, y_op} + 17'(sub_op ^ c_in);
  assign sum_b = {1'b0, x[7:0]} + {1'b0, y_op[7:0]} + 9'(sub_op ^ c_in);
  assign ar    = word_op ? sum_w[15:0] : {8'h00, sum_b[7:0]};
  assign ar_cf = (word_op ? sum_w[16] : sum_b[8]) ^ sub_op;  // Borrow for subtract
  // Like-signed inputs giving an unlike-signed result
  assign ar_of = (msb_x == |(y_op & top)) && (|(ar & top) != msb_x);

  always_comb begin
    case (fn)
      exec_pkg::FN_AND: lg = x & y;
      exec_pkg::FN_OR:  lg = x | y;
      exec_pkg::FN_XOR: lg = x ^ y;
      exec_pkg::FN_NOT: lg = ~x;
      default:          lg = y;  // pass
    endcase
    lg = lg & mask;
  end

  always_comb begin
    sh_cf = msb_x;                           // Bit shifted out to the left
    case (fn)
      exec_pkg::FN_SHL: sh = x << 1;
      exec_pkg::FN_SHR: begin
        sh    = (x & mask) >> 1;
        sh_cf = x[0];
      end
      exec_pkg::FN_SAR: begin
        sh    = ((x & mask) >> 1) | (msb_x ? top : '0);  // Sign kept
        sh_cf = x[0];
      end
      exec_pkg::FN_ROL: sh = (x << 1) | {15'b0, msb_x};
      default: begin                          // ror
        sh    = ((x & mask) >> 1) | (x[0] ? top : '0);
        sh_cf = x[0];
      end
    endcase
    sh = sh & mask;
    case (fn)
      exec_pkg::FN_SHR: sh_of = msb_x;
      exec_pkg::FN_SAR: sh_of = 1'b0;
      exec_pkg::FN_ROR: sh_of = |(sh & top) ^ |(sh & (top >> 1));  // Top two bits differ
      default:          sh_of = |(sh & top) ^ sh_cf;
    endcase
  end

  // Physical address wraps at 1 MB
  assign ea = {seg, 4'h0} + {4'h0, y} + {4'h0, off};

  always_comb begin
    flags_out = flags_in;  // df, if, tf, af pass through
    case (grp)
      exec_pkg::ALU_ARITH: begin
        result = ar;
        flags_out[exec_pkg::FL_OF] = ar_of;
        if (!step)
          flags_out[exec_pkg::FL_CF] = ar_cf;  // inc/dec keep cf
      end
      exec_pkg::ALU_LOGIC: begin
        result = lg;
        flags_out[exec_pkg::FL_OF] = 1'b0;
        flags_out[exec_pkg::FL_CF] = 1'b0;
      end
      exec_pkg::ALU_SHIFT: begin
        result = sh;
        flags_out[exec_pkg::FL_OF] = sh_of;
        flags_out[exec_pkg::FL_CF] = sh_cf;
      end
      default: result = y + off;  // Effective offset
    endcase
    if (grp != exec_pkg::ALU_ADDR) begin
      flags_out[exec_pkg::FL_SF] = |(result & top);
      flags_out[exec_pkg::FL_ZF] = result == '0;
      flags_out[exec_pkg::FL_PF] = ~^result[7:0];  // Even parity of the low byte
    end
  end

  // Result always feeds write-back or addr, so the stage must decode a real group
  always_comb begin
    assert (grp inside {exec_pkg::ALU_ARITH, exec_pkg::ALU_LOGIC,
                        exec_pkg::ALU_SHIFT, exec_pkg::ALU_ADDR})
      else $error("exec_alu: undefined group %0d", grp);
  end

endmodule

`default_nettype wire

/* logic/exec_jmp_cond.sv */
// ======================================================================
// 8086 jump condition decode plus CX-not-zero test
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module exec_jmp_cond (
  input  exec_pkg::flags_t flags,
  input  logic [3:0]       cond,
  input  logic             cx_mode,
  input  logic             cx_zero,
  output logic             jmp
);

  logic base;  // True form of the condition pair
  logic lt;    // Signed less than

  assign lt = flags[exec_pkg::FL_SF] ^ flags[exec_pkg::FL_OF];

  // Conditions come in pairs, odd code is the negation
  always_comb begin
    case (cond[3:1])
      3'd0:    base = flags[exec_pkg::FL_OF];                              // o / no
      3'd1:    base = flags[exec_pkg::FL_CF];                              // b / nb
      3'd2:    base = flags[exec_pkg::FL_ZF];                              // e / ne
      3'd3:    base = flags[exec_pkg::FL_CF] | flags[exec_pkg::FL_ZF];     // be / a
      3'd4:    base = flags[exec_pkg::FL_SF];                              // s / ns
      3'd5:    base = flags[exec_pkg::FL_PF];                              // p / np
      3'd6:    base = lt;                                                  // l / ge
      default: base = lt | flags[exec_pkg::FL_ZF];                         // le / g
    endcase
  end

  assign jmp = cx_mode ? ~cx_zero : base ^ cond[0];

endmodule

`default_nettype wire

/* logic/exec_stage.sv */
// ======================================================================
// Microcode execution stage: field decode, operand and write-back muxes,
// write gating, bus outputs
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
  input  logic               clk,
  input  logic               reset,
  input  exec_pkg::micro_t   ir,
  input  exec_pkg::word_t    imm,
  input  exec_pkg::word_t    off,
  input  exec_pkg::word_t    memout,
  input  logic               block,
  output exec_pkg::word_t    cs,
  output exec_pkg::word_t    ip,
  output logic               of,
  output logic               zf,
  output logic               cx_zero,
  output exec_pkg::word_t    wr_data,
  output exec_pkg::addr20_t  addr,
  output logic               we,
  output logic               m_io,
  output logic               byteop
);

  exec_reg_port_if reg_port ();

  exec_pkg::alu_grp_t grp;
  exec_pkg::alu_fn_t  fn;
  exec_pkg::flags_t   flags, alu_flags;
  exec_pkg::word_t    alu_y, alu_result;
  logic               wrfl, wr, wr_cnd, memalu, b_imm, r_byte;
  logic               jmp, flags_we;

  // Field split
  assign grp    = ir[exec_pkg::GRP_LSB +: 3];
  assign fn     = ir[exec_pkg::FN_LSB +: 3];
  assign wrfl   = ir[exec_pkg::WRFL_BIT];
  assign wr     = ir[exec_pkg::WR_BIT];
  assign wr_cnd = ir[exec_pkg::WRCND_BIT];
  assign memalu = ir[exec_pkg::MEMALU_BIT];
  assign b_imm  = ir[exec_pkg::BIMM_BIT];
  assign r_byte = ir[exec_pkg::RBYTE_BIT];

  // Bus strobes straight from the microword
  assign we     = ir[exec_pkg::WE_BIT];
  assign m_io   = ir[exec_pkg::MIO_BIT];
  assign byteop = ir[exec_pkg::BYTE_BIT];

  assign reg_port.addr_s = ir[exec_pkg::S_LSB +: 2];
  assign reg_port.addr_a = ir[exec_pkg::A_LSB +: 4];
  assign reg_port.addr_b = ir[exec_pkg::B_LSB +: 4];
  assign reg_port.addr_c = ir[exec_pkg::C_LSB +: 4];
  assign reg_port.addr_d = ir[exec_pkg::D_LSB +: 4];
  assign reg_port.a_byte = r_byte;
  assign reg_port.b_byte = r_byte;
  assign reg_port.c_byte = ir[exec_pkg::CBYTE_BIT];

  assign alu_y = b_imm ? imm : reg_port.b;
  assign reg_port.wr_data = memalu ? alu_result : memout;  // Clear memalu for loads
  assign reg_port.wr_byte = byteop;

  // block freezes all state; a conditional write needs jmp
  assign reg_port.wr_en = (wr | (wr_cnd & jmp)) & ~block;
  assign flags_we = wrfl & ~block;

  assign wr_data = reg_port.c;  // Store data from port C
  assign of      = flags[exec_pkg::FL_OF];
  assign zf      = flags[exec_pkg::FL_ZF];
  assign cx_zero = reg_port.cx_zero;

  exec_regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .port     (reg_port.regs),
    .flags_in (alu_flags),
    .flags_we (flags_we),
    .flags    (flags),
    .cs       (cs),
    .ip       (ip)
  );

  exec_alu u_alu (
    .grp       (grp),
    .fn        (fn),
    .x         (reg_port.a),
    .y         (alu_y),
    .seg       (reg_port.s),
    .off       (off),
    .word_op   (~byteop),
    .flags_in  (flags),
    .result    (alu_result),
    .ea        (addr),
    .flags_out (alu_flags)
  );

  // B field doubles as condition code, C field bit 0 as CX mode
  exec_jmp_cond u_jmp_cond (
    .flags   (flags),
    .cond    (reg_port.addr_b),
    .cx_mode (reg_port.addr_c[0]),
    .cx_zero (reg_port.cx_zero),
    .jmp     (jmp)
  );

  // A blocked cycle leaves the visible state untouched
  a_block_hold : assert property (@(posedge clk) disable iff (reset)
                                  block |=> $stable(cs) && $stable(ip) && $stable(flags))
    else $error("exec_stage: state changed while blocked");

endmodule

`default_nettype wire

/* verif/exec_ref_model.svh */
// ======================================================================
// Reference model of the execution stage: register array, flags, ALU
// results, jump conditions, addresses and write-back
// ======================================================================
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

exec_pkg::word_t  m_regs [16];
exec_pkg::flags_t m_flags;

function automatic void model_reset();
  for (int i = 0; i < 16; i++)
    m_regs[i] = '0;
  m_regs[exec_pkg::REG_CS] = exec_pkg::CS_RESET;
  m_regs[exec_pkg::REG_IP] = exec_pkg::IP_RESET;
  m_flags = '0;
endfunction

// Word read or zero-extended 8086 byte view of registers 0..3
function automatic exec_pkg::word_t model_read(input exec_pkg::reg_idx_t idx,
                                               input logic byte_v);
  exec_pkg::word_t w;
  w = m_regs[{2'b00, idx[1:0]}];
  if (!byte_v)
    return m_regs[idx];
  return idx[2] ? {8'h00, w[15:8]} : {8'h00, w[7:0]};
endfunction

function automatic exec_pkg::addr20_t model_addr(input logic [1:0] s, input exec_pkg::word_t y,
                                                 input exec_pkg::word_t off_v);
  exec_pkg::addr20_t seg20;
  seg20 = {4'h0, m_regs[8 + int'(s)]};
  return (seg20 << 4) + {4'h0, y} + {4'h0, off_v};  // Wraps at 1 MB
endfunction

// ALU result and next flags by the 8086 flag rules
function automatic exec_pkg::word_t ref_alu(input exec_pkg::alu_grp_t grp,
    input exec_pkg::alu_fn_t fn, input exec_pkg::word_t x, input exec_pkg::word_t y,
    input exec_pkg::word_t off_v, input logic word_op, input exec_pkg::flags_t fl_in,
    output exec_pkg::flags_t fl_out);
  exec_pkg::word_t mask, top, xm, ym, r;
  logic [16:0] full;
  logic        sx, sy, sr, cin, is_sub;
  int          w;
  w      = word_op ? 16 : 8;
  mask   = word_op ? 16'hffff : 16'h00ff;
  top    = word_op ? 16'h8000 : 16'h0080;
  xm     = x & mask;
  ym     = (grp == exec_pkg::ALU_ARITH &&
            (fn == exec_pkg::FN_INC || fn == exec_pkg::FN_DEC)) ? 16'h0001 : y & mask;
  cin    = fl_in[exec_pkg::FL_CF];
  sx     = |(xm & top);
  fl_out = fl_in;
  r      = '0;
  if (grp == exec_pkg::ALU_ADDR)
    return y + off_v;  // Offset only and flags untouched
  case (grp)
    exec_pkg::ALU_ARITH: begin
      is_sub = fn inside {exec_pkg::FN_SUB, exec_pkg::FN_SBB, exec_pkg::FN_DEC};
      case (fn)
        exec_pkg::FN_ADC: full = {1'b0, xm} + {1'b0, ym} + {16'h0, cin};
        exec_pkg::FN_SUB: full = {1'b0, xm} - {1'b0, ym};
        exec_pkg::FN_SBB: full = {1'b0, xm} - {1'b0, ym} - {16'h0, cin};
        exec_pkg::FN_DEC: full = {1'b0, xm} - {1'b0, ym};
        default:          full = {1'b0, xm} + {1'b0, ym};  // add, inc
      endcase
      r  = full[15:0] & mask;
      sy = |(ym & top);
      sr = |(r & top);
      fl_out[exec_pkg::FL_OF] = is_sub ? (sx != sy) && (sr != sx) : (sx == sy) && (sr != sx);
      if (!(fn inside {exec_pkg::FN_INC, exec_pkg::FN_DEC}))
        fl_out[exec_pkg::FL_CF] = full[w];  // Carry or borrow out
    end
    exec_pkg::ALU_LOGIC: begin
      case (fn)
        exec_pkg::FN_AND: r = xm & ym;
        exec_pkg::FN_OR:  r = xm | ym;
        exec_pkg::FN_XOR: r = xm ^ ym;
        exec_pkg::FN_NOT: r = ~xm & mask;
        default:          r = ym;
      endcase
      fl_out[exec_pkg::FL_OF] = 1'b0;
      fl_out[exec_pkg::FL_CF] = 1'b0;
    end
    default: begin
      case (fn)
        exec_pkg::FN_SHL: r = (xm << 1) & mask;
        exec_pkg::FN_SHR: r = xm >> 1;
        exec_pkg::FN_SAR: r = (xm >> 1) | (sx ? top : 16'h0);
        exec_pkg::FN_ROL: r = ((xm << 1) | {15'h0, sx}) & mask;
        default:          r = (xm >> 1) | (x[0] ? top : 16'h0);
      endcase
      sr = |(r & top);
      fl_out[exec_pkg::FL_CF] = (fn == exec_pkg::FN_SHL || fn == exec_pkg::FN_ROL) ? sx : x[0];
      case (fn)
        exec_pkg::FN_SHR: fl_out[exec_pkg::FL_OF] = sx;
        exec_pkg::FN_SAR: fl_out[exec_pkg::FL_OF] = 1'b0;
        exec_pkg::FN_ROR: fl_out[exec_pkg::FL_OF] = sr ^ |(r & (top >> 1));
        default:          fl_out[exec_pkg::FL_OF] = sr ^ fl_out[exec_pkg::FL_CF];
      endcase
    end
  endcase
  fl_out[exec_pkg::FL_SF] = |(r & top);
  fl_out[exec_pkg::FL_ZF] = r == '0;
  fl_out[exec_pkg::FL_PF] = ~^r[7:0];  // Even parity of the low byte
  return r;
endfunction

// The sixteen 8086 conditions or CX not zero
function automatic logic ref_cond(input logic [3:0] cond, input logic cx_mode);
  logic o, s, z, p, c;
  o = m_flags[exec_pkg::FL_OF];
  s = m_flags[exec_pkg::FL_SF];
  z = m_flags[exec_pkg::FL_ZF];
  p = m_flags[exec_pkg::FL_PF];
  c = m_flags[exec_pkg::FL_CF];
  if (cx_mode)
    return m_regs[exec_pkg::REG_CX] != '0;
  case (cond)
    4'd0:  return o;
    4'd1:  return !o;
    4'd2:  return c;
    4'd3:  return !c;
    4'd4:  return z;
    4'd5:  return !z;
    4'd6:  return c || z;
    4'd7:  return !c && !z;
    4'd8:  return s;
    4'd9:  return !s;
    4'd10: return p;
    4'd11: return !p;
    4'd12: return s != o;
    4'd13: return s == o;
    4'd14: return z || (s != o);
    default: return !z && (s == o);
  endcase
endfunction

// One clock edge of the stage
function automatic void model_step(input exec_pkg::micro_t m, input exec_pkg::word_t imm_v,
    input exec_pkg::word_t off_v, input exec_pkg::word_t mem_v, input logic blk);
  exec_pkg::word_t  x, y, res, data;
  exec_pkg::flags_t nfl;
  exec_pkg::reg_idx_t d;
  logic             do_wr;
  if (blk)
    return;
  x   = model_read(m[exec_pkg::A_LSB +: 4], m[exec_pkg::RBYTE_BIT]);
  y   = m[exec_pkg::BIMM_BIT] ? imm_v
                              : model_read(m[exec_pkg::B_LSB +: 4], m[exec_pkg::RBYTE_BIT]);
  res = ref_alu(m[exec_pkg::GRP_LSB +: 3], m[exec_pkg::FN_LSB +: 3], x, y, off_v,
                !m[exec_pkg::BYTE_BIT], m_flags, nfl);
  data  = m[exec_pkg::MEMALU_BIT] ? res : mem_v;
  do_wr = m[exec_pkg::WR_BIT] ||
          (m[exec_pkg::WRCND_BIT] && ref_cond(m[exec_pkg::B_LSB +: 4], m[exec_pkg::C_LSB]));
  d     = m[exec_pkg::D_LSB +: 4];
  if (do_wr && !m[exec_pkg::BYTE_BIT])
    m_regs[d] = data;
  else if (do_wr && d[2])
    m_regs[{2'b00, d[1:0]}][15:8] = data[7:0];
  else if (do_wr)
    m_regs[{2'b00, d[1:0]}][7:0] = data[7:0];
  if (m[exec_pkg::WRFL_BIT])
    m_flags = nfl;
endfunction

`endif

/* verif/exec_tb.sv */
// ======================================================================
// Testbench for the execution stage: clock, reset, LFSR stimulus,
// reference compare, test sequence and watchdog
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module exec_tb;

  localparam int TEST_CYCLES = 300;  // Six tests summed and rounded up
  localparam int MARGIN      = 100;

  logic               clk, reset, block;
  exec_pkg::micro_t   ir;
  exec_pkg::word_t    imm, off, memout, cs, ip, wr_data;
  exec_pkg::addr20_t  addr;
  logic               of, zf, cx_zero, we, m_io, byteop;

  logic [31:0]        lfsr = 32'h1045_388a;
  int                 errors = 0;
  int                 test_errs;
  string              cur_test = "reset";
  logic               chk_on = 1'b0;
  exec_pkg::word_t    exp_wr, exp_cs, exp_ip;
  exec_pkg::addr20_t  exp_addr;
  logic               exp_addr_en, exp_of, exp_zf, exp_cx, exp_byteop;

  `include "exec_ref_model.svh"

  exec_stage u_exec_stage (
    .clk(clk), .reset(reset), .ir(ir), .imm(imm), .off(off), .memout(memout),
    .block(block), .cs(cs), .ip(ip), .of(of), .zf(zf), .cx_zero(cx_zero),
    .wr_data(wr_data), .addr(addr), .we(we), .m_io(m_io), .byteop(byteop)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // Fibonacci LFSR on taps 32 22 2 1 stepped once per bit
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[14:0], fb};
    end
    return r;
  endfunction

  task automatic check_word(input string what, input exec_pkg::word_t exp,
                            input exec_pkg::word_t act);
    if (exp !== act) begin
      errors++;
      $display("FAIL %s %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_addr(input string what, input exec_pkg::addr20_t exp,
                            input exec_pkg::addr20_t act);
    if (exp !== act) begin
      errors++;
      $display("FAIL %s %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      $display("FAIL %s %s expected %b actual %b", cur_test, what, exp, act);
    end
  endtask

  // Outputs settle after the falling-edge drive and are compared before the edge updates state
  always @(posedge clk) begin
    if (chk_on) begin
      check_word("wr_data", exp_wr, wr_data);
      check_word("cs", exp_cs, cs);
      check_word("ip", exp_ip, ip);
      check_bit("of", exp_of, of);
      check_bit("zf", exp_zf, zf);
      check_bit("cx_zero", exp_cx, cx_zero);
      check_bit("byteop", exp_byteop, byteop);
      if (exp_addr_en)
        check_addr("addr", exp_addr, addr);
    end
  end

  function automatic exec_pkg::micro_t make_ir(input exec_pkg::alu_grp_t grp,
      input exec_pkg::alu_fn_t fn, input logic [3:0] a, input logic [3:0] b,
      input logic [3:0] c, input logic [3:0] d, input logic wr, input logic wrfl);
    exec_pkg::micro_t m;
    m = '0;
    m[exec_pkg::GRP_LSB +: 3]  = grp;
    m[exec_pkg::FN_LSB +: 3]   = fn;
    m[exec_pkg::A_LSB +: 4]    = a;
    m[exec_pkg::B_LSB +: 4]    = b;
    m[exec_pkg::C_LSB +: 4]    = c;
    m[exec_pkg::D_LSB +: 4]    = d;
    m[exec_pkg::WR_BIT]        = wr;
    m[exec_pkg::WRFL_BIT]      = wrfl;
    m[exec_pkg::MEMALU_BIT]    = 1'b1;  // ALU result unless a load
    return m;
  endfunction

  // Drives one micro-instruction and takes expectations from the model before its edge
  task automatic step(input exec_pkg::micro_t m, input exec_pkg::word_t imm_v,
                      input exec_pkg::word_t off_v, input exec_pkg::word_t mem_v, input logic blk);
    exec_pkg::word_t y;
    @(negedge clk);
    ir = m;
    imm = imm_v;
    off = off_v;
    memout = mem_v;
    block = blk;
    y = m[exec_pkg::BIMM_BIT] ? imm_v
                              : model_read(m[exec_pkg::B_LSB +: 4], m[exec_pkg::RBYTE_BIT]);
    exp_wr      = model_read(m[exec_pkg::C_LSB +: 4], m[exec_pkg::CBYTE_BIT]);
    exp_addr_en = m[exec_pkg::GRP_LSB +: 3] == exec_pkg::ALU_ADDR;
    exp_addr    = model_addr(m[exec_pkg::S_LSB +: 2], y, off_v);
    exp_cs      = m_regs[exec_pkg::REG_CS];
    exp_ip      = m_regs[exec_pkg::REG_IP];
    exp_of      = m_flags[exec_pkg::FL_OF];
    exp_zf      = m_flags[exec_pkg::FL_ZF];
    exp_cx      = m_regs[exec_pkg::REG_CX] == '0;
    exp_byteop  = m[exec_pkg::BYTE_BIT];  // Byte strobe follows the microword
    chk_on      = 1'b1;
    model_step(m, imm_v, off_v, mem_v, blk);
  endtask

  task automatic load(input logic [3:0] d, input exec_pkg::word_t v, input logic byte_op);
    exec_pkg::micro_t m;
    m = make_ir(exec_pkg::ALU_LOGIC, exec_pkg::FN_PASS, 4'd0, 4'd0, 4'd0, d, 1'b1, 1'b0);
    m[exec_pkg::BIMM_BIT] = 1'b1;
    m[exec_pkg::BYTE_BIT] = byte_op;
    step(m, v, '0, '0, 1'b0);
  endtask

  task automatic read_reg(input logic [3:0] c, input logic cbyte);
    exec_pkg::micro_t m;
    m = make_ir(exec_pkg::ALU_LOGIC, exec_pkg::FN_PASS, 4'd0, 4'd0, c, 4'd0, 1'b0, 1'b0);
    m[exec_pkg::CBYTE_BIT] = cbyte;
    step(m, '0, '0, '0, 1'b0);
  endtask

  function automatic exec_pkg::micro_t rand_op(input logic [3:0] d);
    exec_pkg::alu_grp_t g;
    exec_pkg::micro_t   m;
    g = exec_pkg::alu_grp_t'(rand_bits(2) % 3);
    m = make_ir(g, exec_pkg::alu_fn_t'(rand_bits(3) % (g == exec_pkg::ALU_ARITH ? 6 : 5)),
                4'(rand_bits(3)), 4'(rand_bits(3)), 4'd0, d, 1'b1, 1'b1);
    m[exec_pkg::BIMM_BIT] = 1'(rand_bits(1));
    return m;
  endfunction

  // Lets the last step of the test reach its compare edge before counting
  task automatic end_test(input int num);
    @(posedge clk);
    #1;
    $display("test %0d %s: %0d errors", num, cur_test, errors - test_errs);
    test_errs = errors;
  endtask

  initial begin
    exec_pkg::micro_t m;
    logic [3:0]       d;
    reset = 1'b1;
    block = 1'b0;
    ir = '0;
    imm = '0;
    off = '0;
    memout = '0;
    test_errs = 0;
    model_reset();
    repeat (4) @(negedge clk);
    reset = 1'b0;

    cur_test = "reset_values";
    check_word("cs", exec_pkg::CS_RESET, cs);
    check_word("ip", exec_pkg::IP_RESET, ip);
    check_bit("we", 1'b0, we);
    check_bit("m_io", 1'b0, m_io);
    end_test(1);

    cur_test = "alu_random";
    for (int i = 0; i < 8; i++)
      load(4'(i), rand_bits(16), 1'b0);
    for (int i = 0; i < 40; i++) begin
      d = 4'(rand_bits(3));
      step(rand_op(d), rand_bits(16), '0, '0, 1'b0);
      read_reg(d, 1'b0);
    end
    end_test(2);

    cur_test = "byte_access";
    for (int i = 0; i < 8; i++) begin
      load(4'(i % 4), rand_bits(16), 1'b0);
      load(4'(i), rand_bits(16), 1'b1);
      read_reg(4'(i), 1'b1);
      read_reg(4'(i % 4), 1'b0);
    end
    end_test(3);

    cur_test = "cond_write";
    for (int k = 0; k < 18; k++) begin
      if (k >= 16)
        load(exec_pkg::REG_CX, k == 16 ? 16'h0 : rand_bits(16) | 16'h1, 1'b0);
      m = make_ir(exec_pkg::ALU_ARITH, exec_pkg::alu_fn_t'(rand_bits(2)), 4'(rand_bits(3)),
                  4'd0, 4'd0, 4'd0, 1'b0, 1'b1);
      m[exec_pkg::BIMM_BIT] = 1'b1;
      step(m, rand_bits(16), '0, '0, 1'b0);
      d = 4'(2 + rand_bits(2));
      m = make_ir(exec_pkg::ALU_LOGIC, exec_pkg::FN_PASS, 4'd0, 4'(k % 16), {3'b0, k >= 16},
                  d, 1'b0, 1'b0);
      m[exec_pkg::BIMM_BIT]  = 1'b1;
      m[exec_pkg::WRCND_BIT] = 1'b1;
      step(m, rand_bits(16), '0, '0, 1'b0);
      read_reg(d, 1'b0);
    end
    end_test(4);

    cur_test = "block_hold";
    for (int i = 0; i < 24; i++)
      step(rand_op(4'(rand_bits(4))), rand_bits(16), '0, rand_bits(16), 1'b1);
    for (int i = 0; i < 16; i++)
      read_reg(4'(i), 1'b0);
    end_test(5);

    cur_test = "addr_load";
    for (int i = 8; i < 12; i++)
      load(4'(i), rand_bits(16), 1'b0);
    for (int i = 0; i < 16; i++) begin
      m = make_ir(exec_pkg::ALU_ADDR, '0, 4'd0, 4'(rand_bits(3)), 4'd0, 4'd0, 1'b0, 1'b0);
      m[exec_pkg::S_LSB +: 2] = 2'(rand_bits(2));
      m[exec_pkg::BIMM_BIT]   = 1'(rand_bits(1));
      step(m, rand_bits(16), rand_bits(16), '0, 1'b0);
    end
    for (int i = 0; i < 12; i++) begin
      d = 4'(rand_bits(3));
      m = make_ir(exec_pkg::ALU_LOGIC, exec_pkg::FN_PASS, 4'd0, 4'd0, 4'd0, d, 1'b1, 1'b0);
      m[exec_pkg::MEMALU_BIT] = 1'b0;  // Memory load
      step(m, rand_bits(16), '0, rand_bits(16), 1'b0);
      read_reg(d, 1'b0);
    end
    end_test(6);

    $display("summary: 6 tests, %0d errors", errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  initial begin
    #((TEST_CYCLES + MARGIN) * 100);
    $display("watchdog: run did not finish within %0d cycles", TEST_CYCLES + MARGIN);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verif
logic/exec_pkg.sv
logic/exec_reg_port_if.sv
logic/exec_regfile.sv
logic/exec_alu.sv
logic/exec_jmp_cond.sv
logic/exec_stage.sv
verif/exec_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= exec_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
